//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // RV32I major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // funct7 of SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [1:0]  size_t;

    // Word access
    localparam size_t SIZE_WORD = 2'd2;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_FETCH,
        GRANT_DATA
    } grant_e;

endpackage

`default_nettype wire

//--- verilog/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n,
    output logic            fetch_req,
    output bus_pkg::addr_t  fetch_addr,
    input  logic            fetch_ack,
    input  core_pkg::word_t fetch_rdata,
    output logic            instr_valid,
    output core_pkg::word_t instr,
    output bus_pkg::addr_t  instr_pc,
    input  logic            take,
    input  logic            redirect,
    input  bus_pkg::addr_t  redirect_pc
);
    import core_pkg::*;
    import bus_pkg::*;

    addr_t pc;
    addr_t start_pc;
    logic  start;
    logic  discard;

    // Next address to fetch
    assign start_pc = redirect ? redirect_pc : pc;
    // Begin a fetch once the buffer is empty or being taken
    assign start = !fetch_req && (!instr_valid || take);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= RESET_PC;
            fetch_req   <= 1'b0;
            instr_valid <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (start) begin
                fetch_req  <= 1'b1;
                fetch_addr <= start_pc;
                pc         <= start_pc + 32'd4;
            end else if (redirect) begin
                pc <= redirect_pc;
            end
            if (fetch_ack) begin
                fetch_req <= 1'b0;
            end
            if (take || redirect) begin
                instr_valid <= 1'b0;
            end
            // Stale data after a redirect is dropped
            if (fetch_ack && !discard && !redirect) begin
                instr_valid <= 1'b1;
                instr       <= fetch_rdata;
                instr_pc    <= fetch_addr;
            end
            if (redirect && fetch_req && !fetch_ack) begin
                discard <= 1'b1;
            end else if (fetch_ack) begin
                discard <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    // x1..x31 only
    word_t regs [1:31];

    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  core_pkg::word_t     instr,
    input  bus_pkg::addr_t      instr_pc,
    output logic                take,
    output logic                redirect,
    output bus_pkg::addr_t      redirect_pc,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    input  core_pkg::word_t     rdata1,
    input  core_pkg::word_t     rdata2,
    output logic                we,
    output core_pkg::reg_addr_t waddr,
    output core_pkg::word_t     wdata,
    output logic                ls_start,
    output bus_pkg::addr_t      ls_addr,
    output core_pkg::word_t     ls_wdata,
    output logic                ls_write,
    input  logic                ls_done,
    input  core_pkg::word_t     ls_rdata
);
    import core_pkg::*;

    typedef enum logic {
        EX_RUN,
        EX_WAIT_MEM
    } ex_state_e;

    ex_state_e state;
    opcode_t   opcode;
    funct3_t   funct3;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     alu_b;
    word_t     alu_result;
    alu_op_e   alu_op;
    logic      is_mem;
    logic      is_write_back;
    logic      branch_taken;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign waddr  = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};

    assign is_mem        = (opcode == OP_LOAD) || (opcode == OP_STORE);
    assign is_write_back = (opcode == OP_LUI) || (opcode == OP_IMM) || (opcode == OP_REG);

    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OP_LUI) begin
            alu_op = ALU_PASS_B;
        end else if (opcode == OP_IMM || opcode == OP_REG) begin
            case (funct3)
                F3_XOR:  alu_op = ALU_XOR;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
                // SUB only exists in register form
                F3_ADD:  alu_op = (opcode == OP_REG && instr[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign alu_b = (opcode == OP_REG) ? rdata2 : (opcode == OP_LUI) ? imm_u : imm_i;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = rdata1 + alu_b;
            ALU_SUB:    alu_result = rdata1 - alu_b;
            ALU_AND:    alu_result = rdata1 & alu_b;
            ALU_OR:     alu_result = rdata1 | alu_b;
            ALU_XOR:    alu_result = rdata1 ^ alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = rdata1 + alu_b;
        endcase
    end

    always_comb begin
        branch_taken = 1'b0;
        if (opcode == OP_BRANCH) begin
            if (funct3 == F3_BEQ) begin
                branch_taken = (rdata1 == rdata2);
            end else if (funct3 == F3_BNE) begin
                branch_taken = (rdata1 != rdata2);
            end
        end
    end

    assign redirect    = (state == EX_RUN) && instr_valid && branch_taken;
    assign redirect_pc = instr_pc + imm_b;

    assign ls_addr  = rdata1 + ((opcode == OP_STORE) ? imm_s : imm_i);
    assign ls_wdata = rdata2;
    assign ls_write = (opcode == OP_STORE);

    always_comb begin
        take     = 1'b0;
        we       = 1'b0;
        ls_start = 1'b0;
        wdata    = alu_result;
        if (state == EX_WAIT_MEM) begin
            if (ls_done) begin
                take  = 1'b1;
                we    = (opcode == OP_LOAD);
                wdata = ls_rdata;
            end
        end else if (instr_valid) begin
            if (is_mem) begin
                ls_start = 1'b1;
            end else begin
                take = 1'b1;
                we   = is_write_back;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EX_RUN;
        end else begin
            case (state)
                EX_RUN: begin
                    if (instr_valid && is_mem) begin
                        state <= EX_WAIT_MEM;
                    end
                end
                EX_WAIT_MEM: begin
                    if (ls_done) begin
                        state <= EX_RUN;
                    end
                end
                default: state <= EX_RUN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ls_start,
    input  bus_pkg::addr_t  ls_addr,
    input  core_pkg::word_t ls_wdata,
    input  logic            ls_write,
    output logic            ls_done,
    output core_pkg::word_t ls_rdata,
    output logic            data_req,
    output bus_pkg::addr_t  data_addr,
    output core_pkg::word_t data_wdata,
    output logic            data_write,
    input  logic            data_ack,
    input  core_pkg::word_t data_rdata
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_req <= 1'b0;
            ls_done  <= 1'b0;
        end else begin
            ls_done <= data_ack;
            if (ls_start) begin
                data_req <= 1'b1;
            end else if (data_ack) begin
                data_req <= 1'b0;
            end
        end
    end

    // Request fields stay put until the ack
    always_ff @(posedge clk) begin
        if (ls_start) begin
            data_addr  <= ls_addr;
            data_wdata <= ls_wdata;
            data_write <= ls_write;
        end
        if (data_ack) begin
            ls_rdata <= data_rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_req,
    input  bus_pkg::addr_t  fetch_addr,
    output logic            fetch_ack,
    output core_pkg::word_t fetch_rdata,
    input  logic            data_req,
    input  bus_pkg::addr_t  data_addr,
    input  core_pkg::word_t data_wdata,
    input  logic            data_write,
    output logic            data_ack,
    output core_pkg::word_t data_rdata,
    output bus_pkg::addr_t  mem_addr,
    output core_pkg::word_t mem_wdata,
    input  core_pkg::word_t mem_rdata,
    output logic            mem_req,
    output logic            mem_write,
    output bus_pkg::size_t  mem_size,
    input  logic            mem_ack_n
);
    import bus_pkg::*;

    grant_e grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= GRANT_NONE;
        end else if (grant == GRANT_NONE) begin
            // Data side first
            if (data_req) begin
                grant <= GRANT_DATA;
            end else if (fetch_req) begin
                grant <= GRANT_FETCH;
            end
        end else if (!mem_ack_n) begin
            grant <= GRANT_NONE;
        end
    end

    assign mem_req   = (grant != GRANT_NONE);
    assign mem_write = (grant == GRANT_DATA) && data_write;
    assign mem_addr  = (grant == GRANT_DATA) ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;
    assign mem_size  = SIZE_WORD;

    assign fetch_ack   = (grant == GRANT_FETCH) && !mem_ack_n;
    assign data_ack    = (grant == GRANT_DATA) && !mem_ack_n;
    assign fetch_rdata = (grant == GRANT_FETCH) ? mem_rdata : 32'd0;
    assign data_rdata  = (grant == GRANT_DATA) ? mem_rdata : 32'd0;

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`default_nettype none

module core_top (
    input  logic            clk,
    input  logic            rst_n,
    output bus_pkg::addr_t  mem_addr,
    output core_pkg::word_t mem_wdata,
    input  core_pkg::word_t mem_rdata,
    output logic            mem_req,
    output logic            mem_write,
    output bus_pkg::size_t  mem_size,
    input  logic            mem_ack_n
);
    import core_pkg::*;
    import bus_pkg::*;

    // Fetch side
    logic      fetch_req, fetch_ack;
    addr_t     fetch_addr;
    word_t     fetch_rdata;
    logic      instr_valid, take, redirect;
    word_t     instr;
    addr_t     instr_pc, redirect_pc;

    // Register file
    reg_addr_t rs1, rs2, waddr;
    word_t     rdata1, rdata2, wdata;
    logic      we;

    // Data side
    logic      ls_start, ls_write, ls_done;
    addr_t     ls_addr;
    word_t     ls_wdata, ls_rdata;
    logic      data_req, data_write, data_ack;
    addr_t     data_addr;
    word_t     data_wdata, data_rdata;

    fetch_unit fetch_unit_inst (.*);

    exec_unit exec_unit_inst (.*);

    reg_file reg_file_inst (.*);

    load_store_unit load_store_unit_inst (.*);

    bus_arbiter bus_arbiter_inst (.*);

endmodule

`default_nettype wire

//--- tests/tb_mem.sv
`default_nettype none

module tb_mem #(
    parameter int WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  bus_pkg::addr_t  mem_addr,
    input  core_pkg::word_t mem_wdata,
    output core_pkg::word_t mem_rdata,
    input  logic            mem_req,
    input  logic            mem_write,
    output logic            mem_ack_n,
    input  logic            load_image,
    input  core_pkg::word_t image [WORDS],
    output logic            store_valid,
    output bus_pkg::addr_t  store_addr,
    output core_pkg::word_t store_data
);
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import bus_pkg::*;

    localparam int AW = $clog2(WORDS);

    word_t mem [WORDS];
    logic  busy;
    int    wait_cycles;
    logic  req_s;
    logic  write_s;
    logic  rst_s;
    logic  ack_s;
    logic  load_s;
    addr_t addr_s;
    word_t wdata_s;

    initial begin
        mem_ack_n   = 1'b1;
        mem_rdata   = '0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        busy        = 1'b0;
        wait_cycles = 0;
    end

    always @(posedge clk) begin
        // Sample at the edge and answer 1 ns later
        req_s   = mem_req;
        write_s = mem_write;
        rst_s   = rst_n;
        ack_s   = !mem_ack_n;
        load_s  = load_image;
        addr_s  = mem_addr;
        wdata_s = mem_wdata;
        #1;
        mem_ack_n   = 1'b1;
        store_valid = 1'b0;
        if (load_s) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] = image[i];
            end
        end
        if (!rst_s || ack_s) begin
            busy = 1'b0;
        end else if (req_s) begin
            if (!busy) begin
                busy        = 1'b1;
                wait_cycles = $urandom % 4;
            end
            if (wait_cycles == 0) begin
                mem_ack_n = 1'b0;
                if (write_s) begin
                    mem[addr_s[AW+1:2]] = wdata_s;
                    store_valid = 1'b1;
                    store_addr  = addr_s;
                    store_data  = wdata_s;
                end else begin
                    mem_rdata = mem[addr_s[AW+1:2]];
                end
            end else begin
                wait_cycles--;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import bus_pkg::*;

    localparam int    MEM_WORDS      = 256;
    localparam int    TIMEOUT_CYCLES = 60 * 8;
    localparam addr_t START_PC       = 32'h0000_0000;
    localparam addr_t DATA_BASE      = 32'h0000_0200;
    localparam addr_t LOOP_ADDR      = 32'h0000_0300;
    localparam addr_t SKIP_ADDR      = 32'h0000_0380;
    localparam addr_t MARKER         = 32'h0000_03fc;

    logic  clk;
    logic  rst_n;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_req;
    logic  mem_write;
    size_t mem_size;
    logic  mem_ack_n;
    logic  load_image;
    word_t image [MEM_WORDS];
    logic  store_valid;
    addr_t store_addr;
    word_t store_data;

    // Bus observations are cleared at every reset
    addr_t store_addrs[$];
    word_t store_datas[$];
    logic  first_seen;
    addr_t first_addr;
    logic  first_write;
    logic  bad_size;

    word_t prog[$];
    addr_t exp_addr[$];
    word_t exp_data[$];
    int    next_slot;
    int    errors;
    int    tests_passed;
    int    tests_failed;
    int    test_id = 0;
    int    watched_id = 0;
    int    cycle_count = 0;

    core_top i_dut (
        .clk, .rst_n, .mem_addr, .mem_wdata, .mem_rdata,
        .mem_req, .mem_write, .mem_size, .mem_ack_n
    );

    tb_mem #(.WORDS(MEM_WORDS)) i_mem (
        .clk, .rst_n, .mem_addr, .mem_wdata, .mem_rdata, .mem_req, .mem_write,
        .mem_ack_n, .load_image, .image, .store_valid, .store_addr, .store_data
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n) begin
            store_addrs.delete();
            store_datas.delete();
            first_seen = 1'b0;
            bad_size   = 1'b0;
        end else begin
            if (store_valid) begin
                store_addrs.push_back(store_addr);
                store_datas.push_back(store_data);
            end
            if (mem_req && !first_seen) begin
                first_seen  = 1'b1;
                first_addr  = mem_addr;
                first_write = mem_write;
            end
            if (mem_req && mem_size != SIZE_WORD) begin
                bad_size = 1'b1;
            end
        end
    end

    // Restarts at every reset
    always @(posedge clk) begin
        if (test_id != watched_id) begin
            watched_id  = test_id;
            cycle_count = 0;
        end else begin
            cycle_count++;
        end
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: no marker store within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // RV32I encodings
    function automatic word_t reg_op(input logic [6:0] f7, input funct3_t f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t imm_op(input funct3_t f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t lui(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t base,
                                        input logic [11:0] offset);
        return {offset, base, 3'b010, rd, OP_LOAD};
    endfunction

    function automatic word_t store_word(input reg_addr_t src, input reg_addr_t base,
                                         input logic [11:0] offset);
        return {offset[11:5], src, base, 3'b010, offset[4:0], OP_STORE};
    endfunction

    function automatic word_t branch(input funct3_t f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], OP_BRANCH};
    endfunction

    task automatic begin_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        next_slot = 0;
        errors    = 0;
    endtask

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic expect_store(input addr_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    // Store to the next free data word and expect it
    task automatic store_reg(input reg_addr_t r, input word_t value);
        addr_t a;
        a = DATA_BASE + 4 * next_slot;
        emit(store_word(r, 5'd0, a[11:0]));
        expect_store(a, value);
        next_slot++;
    endtask

    task automatic fill_image();
        addr_t a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = addr_t'(i) << 2;
            image[i] = ~a ^ (a << 16);
        end
        foreach (prog[i]) begin
            image[i] = prog[i];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n      = 1'b0;
        load_image = 1'b1;
        test_id++;
        @(posedge clk);
        #1;
        load_image = 1'b0;
        @(negedge clk);
        if (mem_req) begin
            $display("mem_req is high while reset is applied");
            errors++;
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_marker();
        do begin
            @(negedge clk);
        end while (store_addrs.size() == 0 || store_addrs[store_addrs.size() - 1] != MARKER);
    endtask

    task automatic compare_stores(input string name);
        int got;
        got = store_addrs.size() - 1;
        if (got != exp_addr.size()) begin
            $display("FAILED %s: store count expected %0d, got %0d", name, exp_addr.size(), got);
            errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < got; i++) begin
            if (store_addrs[i] != exp_addr[i]) begin
                $display("FAILED %s: store %0d address expected %h, got %h",
                         name, i, exp_addr[i], store_addrs[i]);
                errors++;
            end
            if (store_datas[i] != exp_data[i]) begin
                $display("FAILED %s: store %0d data expected %h, got %h",
                         name, i, exp_data[i], store_datas[i]);
                errors++;
            end
        end
    endtask

    // Ends with a marker store and a branch to itself
    task automatic run_program(input string name, input int interrupt);
        emit(store_word(5'd0, 5'd0, MARKER[11:0]));
        emit(branch(F3_BEQ, 5'd0, 5'd0, 13'd0));
        fill_image();
        if (interrupt > 0) begin
            apply_reset();
            repeat (interrupt) @(posedge clk);
        end
        apply_reset();
        wait_marker();
        if (!first_seen || first_addr != START_PC || first_write) begin
            $display("%s: first bus access after reset is not a fetch from zero", name);
            errors++;
        end
        if (bad_size) begin
            $display("%s: an access used a size other than word", name);
            errors++;
        end
        compare_stores(name);
        if (errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors);
        end
    endtask

    task automatic alu_results();
        word_t v [11];
        begin_test();
        v[1]  = 32'h1234_5000;
        v[2]  = 32'd0 - 32'd5;
        v[3]  = v[1] + 32'h7ff;
        v[4]  = v[1] + v[2];
        v[5]  = v[2] - v[1];
        v[6]  = v[1] & v[2];
        v[7]  = v[2] | v[3];
        v[8]  = v[2] ^ v[3];
        v[9]  = 32'h8000_0000;
        v[10] = v[9] + v[9];
        emit(lui(5'd1, 20'h12345));
        emit(imm_op(F3_ADD, 5'd2, 5'd0, 12'hffb));
        emit(imm_op(F3_ADD, 5'd3, 5'd1, 12'h7ff));
        emit(reg_op(7'd0, F3_ADD, 5'd4, 5'd1, 5'd2));
        emit(reg_op(F7_SUB, F3_ADD, 5'd5, 5'd2, 5'd1));
        emit(reg_op(7'd0, F3_AND, 5'd6, 5'd1, 5'd2));
        emit(reg_op(7'd0, F3_OR, 5'd7, 5'd2, 5'd3));
        emit(reg_op(7'd0, F3_XOR, 5'd8, 5'd2, 5'd3));
        emit(lui(5'd9, 20'h80000));
        emit(reg_op(7'd0, F3_ADD, 5'd10, 5'd9, 5'd9));
        for (int r = 1; r <= 10; r++) begin
            store_reg(reg_addr_t'(r), v[r]);
        end
        run_program("alu_ops", 0);
    endtask

    task automatic x0_stays_zero();
        begin_test();
        emit(imm_op(F3_ADD, 5'd0, 5'd0, 12'd123));
        emit(imm_op(F3_ADD, 5'd1, 5'd0, 12'd77));
        emit(reg_op(7'd0, F3_ADD, 5'd0, 5'd1, 5'd1));
        emit(lui(5'd0, 20'hfffff));
        store_reg(5'd0, 32'd0);
        store_reg(5'd1, 32'd77);
        emit(reg_op(7'd0, F3_ADD, 5'd2, 5'd0, 5'd1));
        store_reg(5'd2, 32'd77);
        run_program("x0_zero", 0);
    endtask

    task automatic load_after_store();
        addr_t a;
        word_t v;
        begin_test();
        a = DATA_BASE + 32'h80;
        v = 32'habcd_e5a5;
        emit(lui(5'd2, 20'habcde));
        emit(imm_op(F3_ADD, 5'd1, 5'd0, 12'h5a5));
        emit(reg_op(7'd0, F3_OR, 5'd2, 5'd2, 5'd1));
        emit(store_word(5'd2, 5'd0, a[11:0]));
        expect_store(a, v);
        emit(load_word(5'd3, 5'd0, a[11:0]));
        emit(imm_op(F3_ADD, 5'd4, 5'd3, 12'h010));
        emit(reg_op(7'd0, F3_ADD, 5'd5, 5'd3, 5'd1));
        store_reg(5'd3, v);
        store_reg(5'd4, v + 32'h10);
        store_reg(5'd5, v + 32'h5a5);
        run_program("load_after_store", 0);
    endtask

    task automatic branch_paths();
        begin_test();
        emit(imm_op(F3_ADD, 5'd1, 5'd0, 12'd5));
        emit(imm_op(F3_ADD, 5'd2, 5'd0, 12'd5));
        emit(imm_op(F3_ADD, 5'd3, 5'd0, 12'd7));
        // Taken branches skip the next store
        emit(branch(F3_BEQ, 5'd1, 5'd2, 13'd8));
        emit(store_word(5'd3, 5'd0, SKIP_ADDR[11:0]));
        store_reg(5'd1, 32'd5);
        emit(branch(F3_BNE, 5'd1, 5'd3, 13'd8));
        emit(store_word(5'd3, 5'd0, SKIP_ADDR[11:0]));
        store_reg(5'd2, 32'd5);
        // Not taken
        emit(branch(F3_BEQ, 5'd1, 5'd3, 13'd8));
        store_reg(5'd3, 32'd7);
        emit(branch(F3_BNE, 5'd1, 5'd2, 13'd8));
        store_reg(5'd1, 32'd5);
        // Countdown loop closed by a backward BNE
        emit(imm_op(F3_ADD, 5'd4, 5'd0, 12'd3));
        emit(imm_op(F3_ADD, 5'd4, 5'd4, 12'hfff));
        emit(store_word(5'd4, 5'd0, LOOP_ADDR[11:0]));
        emit(branch(F3_BNE, 5'd4, 5'd0, 13'h1ff8));
        for (int k = 2; k >= 0; k--) begin
            expect_store(LOOP_ADDR, 32'(k));
        end
        run_program("branches", 0);
    endtask

    task automatic build_mem_mix(input int count);
        word_t v;
        addr_t a;
        for (int k = 0; k < count; k++) begin
            v = $urandom % 2048;
            a = DATA_BASE + 4 * next_slot;
            emit(imm_op(F3_ADD, 5'd1, 5'd0, v[11:0]));
            store_reg(5'd1, v);
            emit(load_word(5'd2, 5'd0, a[11:0]));
            emit(imm_op(F3_ADD, 5'd2, 5'd2, 12'd1));
            store_reg(5'd2, v + 32'd1);
        end
    endtask

    task automatic random_ack_delays();
        begin_test();
        build_mem_mix(6);
        run_program("back_pressure", 0);
    endtask

    task automatic reset_mid_program();
        begin_test();
        build_mem_mix(4);
        run_program("mid_run_reset", 40);
    endtask

    initial begin
        void'($urandom(32'hd4c0));
        clk          = 1'b0;
        rst_n        = 1'b0;
        load_image   = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        alu_results();
        x0_stays_zero();
        load_after_store();
        branch_paths();
        random_ack_delays();
        reset_mid_program();
        $display("%0d tests, %0d passed, %0d failed",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/core_pkg.sv
verilog/bus_pkg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/core_top.sv
tests/tb_mem.sv
tests/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
